// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := itim_tb
FILELIST := itim.f
LOG      := sim.log
PASS     := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then echo "test: pass"; else echo "test: fail"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/itim.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim import itim_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  input  logic        fetch_fence,
  input  logic [31:0] fetch_addr,
  output logic        fetch_ready,
  output logic [63:0] fetch_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic [31:0] mem_rdata,
  input  logic        mem_ready
);

  logic                                 req_valid;
  logic                                 req_fence;
  itim_addr_t                           req_addr0;
  itim_addr_t                           req_addr1;
  logic [itim_banks-1:0][index_bits-1:0] read_index;
  logic [itim_banks-1:0][entry_bits-1:0] read_entry;
  logic [itim_banks-1:0]                write_enable;
  logic [index_bits-1:0]                write_index;
  logic [entry_bits-1:0]                write_entry;

  itim_front u_front (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .req_valid   (req_valid),
    .req_fence   (req_fence),
    .req_addr0   (req_addr0),
    .req_addr1   (req_addr1),
    .read_index  (read_index)
  );

  // word-interleaved banks.
  for (genvar i = 0; i < itim_banks; i++) begin : g_bank
    itim_bank u_bank (
      .clock        (clock),
      .write_enable (write_enable[i]),
      .write_index  (write_index),
      .write_entry  (write_entry),
      .read_index   (read_index[i]),
      .read_entry   (read_entry[i])
    );
  end

  itim_ctrl u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_fence    (req_fence),
    .req_addr0    (req_addr0),
    .req_addr1    (req_addr1),
    .read_entry   (read_entry),
    .write_enable (write_enable),
    .write_index  (write_index),
    .write_entry  (write_entry),
    .fetch_ready  (fetch_ready),
    .fetch_rdata  (fetch_rdata),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready)
  );

endmodule

`default_nettype wire

// ==== hw/itim_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_bank import itim_pkg::*; (
  input  logic                  clock,
  input  logic                  write_enable,
  input  logic [index_bits-1:0] write_index,
  input  logic [entry_bits-1:0] write_entry,
  input  logic [index_bits-1:0] read_index,
  output logic [entry_bits-1:0] read_entry
);

  logic [entry_bits-1:0] entries [itim_depth];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      entries[write_index] <= write_entry;
    end
  end

  // one cycle read. a read at the index being written sees the old entry.
  always_ff @(posedge clock) begin
    read_entry <= entries[read_index];
  end

endmodule

`default_nettype wire

// ==== hw/itim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_ctrl import itim_pkg::*; (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 req_valid,
  input  logic                                 req_fence,
  input  itim_addr_t                           req_addr0,
  input  itim_addr_t                           req_addr1,
  input  logic [itim_banks-1:0][entry_bits-1:0] read_entry,
  output logic [itim_banks-1:0]                write_enable,
  output logic [index_bits-1:0]                write_index,
  output logic [entry_bits-1:0]                write_entry,
  output logic                                 fetch_ready,
  output logic [63:0]                          fetch_rdata,
  output logic                                 mem_valid,
  output logic [31:0]                          mem_addr,
  input  logic [31:0]                          mem_rdata,
  input  logic                                 mem_ready
);

  logic [1:0]            state;
  logic                  beat;
  logic [index_bits-1:0] fence_index;
  logic [31:0]           low_word;

  logic [entry_bits-1:0] entry0;
  logic [entry_bits-1:0] entry1;
  logic                  outside;
  logic                  go_fence;
  logic                  go_bypass;
  logic                  go_fill;
  logic                  go_hit;
  logic                  last_index;
  itim_addr_t            cur_addr;

  ////////////////////////////////////////////////////////////////////////////
  // classify the request.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    entry0 = read_entry[req_addr0.field.bank];
    entry1 = read_entry[req_addr1.field.bank];

    outside = (req_addr0.raw < itim_base_addr) || (req_addr0.raw >= itim_top_addr) ||
              (req_addr1.raw < itim_base_addr) || (req_addr1.raw >= itim_top_addr);

    go_fence  = 1'b0;
    go_bypass = 1'b0;
    go_fill   = 1'b0;
    go_hit    = 1'b0;

    // fence first, then window, then empty, then owner tag.
    if (req_valid && state == state_idle) begin
      if (req_fence) begin
        go_fence = 1'b1;
      end else if (outside) begin
        go_bypass = 1'b1;
      end else if (!entry0[entry_bits-1] || !entry1[entry_bits-1]) begin
        go_fill = 1'b1;
      end else if (entry0[entry_bits-2 -: tag_bits] != req_addr0.field.tag ||
                   entry1[entry_bits-2 -: tag_bits] != req_addr1.field.tag) begin
        go_bypass = 1'b1;
      end else begin
        go_hit = 1'b1;
      end
    end
  end

  // the word being fetched from memory in this beat.
  assign cur_addr   = beat ? req_addr1 : req_addr0;
  assign last_index = (fence_index == index_bits'(itim_depth - 1));

  ////////////////////////////////////////////////////////////////////////////
  // outputs.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    write_enable = '0;
    write_index  = fence_index;
    write_entry  = '0;
    fetch_ready  = 1'b0;
    fetch_rdata  = '0;
    mem_valid    = 1'b0;
    mem_addr     = cur_addr.raw;

    case (state)
      state_idle: begin
        if (go_hit) begin
          fetch_ready = 1'b1;
          fetch_rdata = {entry1[31:0], entry0[31:0]};
        end
        // the first beat starts in the decision cycle.
        mem_valid = go_fill | go_bypass;
      end
      state_fill, state_bypass: begin
        mem_valid = 1'b1;
        if (mem_ready) begin
          if (state == state_fill) begin
            write_enable[cur_addr.field.bank] = 1'b1;
            write_index = cur_addr.field.index;
            write_entry = {1'b1, cur_addr.field.tag, mem_rdata};
          end
          if (beat) begin
            fetch_ready = 1'b1;
            fetch_rdata = {mem_rdata, low_word};
          end
        end
      end
      default: begin
        // fence clears one index in every bank.
        write_enable = '1;
        fetch_ready  = last_index;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= state_idle;
      beat        <= 1'b0;
      fence_index <= '0;
    end else begin
      case (state)
        state_idle: begin
          beat        <= 1'b0;
          fence_index <= '0;
          if (go_fence) begin
            state <= state_fence;
          end else if (go_bypass) begin
            state <= state_bypass;
          end else if (go_fill) begin
            state <= state_fill;
          end
        end
        state_fill, state_bypass: begin
          if (mem_ready) begin
            beat <= ~beat;
            if (beat) begin
              state <= state_idle;
            end
          end
        end
        default: begin
          fence_index <= fence_index + 1'b1;
          if (last_index) begin
            state <= state_idle;
          end
        end
      endcase
    end
  end

  // lower word of the response is kept until the second beat.
  always_ff @(posedge clock) begin
    if ((state == state_fill || state == state_bypass) && mem_ready && !beat) begin
      low_word <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/itim_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_front import itim_pkg::*; (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 fetch_valid,
  input  logic                                 fetch_fence,
  input  logic [31:0]                          fetch_addr,
  output logic                                 req_valid,
  output logic                                 req_fence,
  output itim_addr_t                           req_addr0,
  output itim_addr_t                           req_addr1,
  output logic [itim_banks-1:0][index_bits-1:0] read_index
);

  itim_addr_t next_addr0;
  itim_addr_t next_addr1;

  // the second word follows the first one.
  always_comb begin
    next_addr0.raw = fetch_addr;
    next_addr1.raw = fetch_addr + 32'd4;
  end

  // each word goes to its own bank, so the two reads never collide.
  // banks that are not addressed simply read index zero.
  always_comb begin
    read_index = '0;
    read_index[next_addr0.field.bank] = next_addr0.field.index;
    read_index[next_addr1.field.bank] = next_addr1.field.index;
  end

  ////////////////////////////////////////////////////////////////////////////
  // request register.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_valid <= 1'b0;
      req_fence <= 1'b0;
    end else begin
      req_valid <= fetch_valid;
      req_fence <= fetch_valid & fetch_fence;
    end
  end

  // addresses hold until the next strobe because the controller reads them
  // throughout a memory access.
  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      req_addr0 <= next_addr0;
      req_addr1 <= next_addr1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/itim_pkg.sv ====
`default_nettype none

package itim_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry.
  ////////////////////////////////////////////////////////////////////////////

  localparam int itim_depth = 16;
  localparam int itim_banks = 4;
  localparam int index_bits = 4;
  localparam int bank_bits  = 2;
  localparam int tag_bits   = 24;

  // valid bit, tag, then the instruction word.
  localparam int entry_bits = 1 + tag_bits + 32;

  // fetches inside [base, top) may be cached.
  localparam logic [31:0] itim_base_addr = 32'h0000_1000;
  localparam logic [31:0] itim_top_addr  = 32'h0000_2000;

  ////////////////////////////////////////////////////////////////////////////
  // controller states.
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] state_idle   = 2'd0;
  localparam logic [1:0] state_fill   = 2'd1;
  localparam logic [1:0] state_bypass = 2'd2;
  localparam logic [1:0] state_fence  = 2'd3;

  // one fetch address seen whole or split into its cache fields.
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_bits-1:0]   tag;
      logic [index_bits-1:0] index;
      logic [bank_bits-1:0]  bank;
      logic [1:0]            offset;
    } field;
  } itim_addr_t;

endpackage

`default_nettype wire

// ==== itim.f ====
hw/itim_pkg.sv
hw/itim_bank.sv
hw/itim_front.sv
hw/itim_ctrl.sv
hw/itim.sv
tb/itim_tb.sv

// ==== tb/itim_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_tb;

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic        fetch_fence;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  logic [63:0] fetch_rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_rdata = '0;
  logic        mem_ready = 1'b0;

  // one entry per vector line.
  logic [39:0] vec_kind [$];
  logic [31:0] vec_addr [$];
  logic [63:0] vec_data [$];
  int          vec_beats [$];

  int          error_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          total_beats = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        mem_busy = 1'b0;
  int unsigned mem_wait = 0;

  itim dut (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_rdata   (mem_rdata),
    .mem_ready   (mem_ready)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // memory model that answers each beat after 1 to 4 cycles with ~address.
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    mem_ready <= 1'b0;
    if (!reset) begin
      mem_busy <= 1'b0;
    end else if (mem_busy) begin
      if (mem_wait <= 1) begin
        mem_ready   <= 1'b1;
        mem_rdata   <= ~mem_addr;
        mem_busy    <= 1'b0;
        total_beats <= total_beats + 1;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (mem_valid && !mem_ready) begin
      mem_busy <= 1'b1;
      mem_wait <= ($urandom % 4) + 1;
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the DUT gave no response within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks.
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_rdata(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_beats(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic read_vectors();
    int              fd;
    int              n;
    logic [39:0]     kind;
    logic [31:0]     addr;
    logic [63:0]     data;
    int              beats;
    logic [1279:0]   line;
    fd = $fopen("tb/itim_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tb/itim_vectors.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      kind = '0;
      n = $fscanf(fd, "%s", kind);
      if (n != 1) begin
        break;
      end
      if (kind == "#") begin
        // rest of a comment line.
        n = $fgets(line, fd);
      end else begin
        n = $fscanf(fd, "%h %h %d", addr, data, beats);
        if (n == 3 && (kind == "fetch" || kind == "fence")) begin
          vec_kind.push_back(kind);
          vec_addr.push_back(addr);
          vec_data.push_back(data);
          vec_beats.push_back(beats);
        end else begin
          $display("vector %0d in the file cannot be read", vec_addr.size());
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int i);
    logic        is_fence;
    int          beats_before;
    int          errors_before;
    int          latency;
    logic [63:0] rdata;
    is_fence      = (vec_kind[i] == "fence");
    errors_before = error_count;
    beats_before  = total_beats;
    @(posedge clock);
    fetch_valid <= 1'b1;
    fetch_fence <= is_fence;
    fetch_addr  <= vec_addr[i];
    // the DUT samples the strobe at this edge.
    @(posedge clock);
    fetch_valid <= 1'b0;
    fetch_fence <= 1'b0;
    latency = 1;
    @(negedge clock);
    while (!fetch_ready) begin
      latency++;
      @(negedge clock);
    end
    rdata = fetch_rdata;
    if (!is_fence) begin
      check_rdata("fetch_rdata", vec_data[i], rdata);
    end
    check_beats("mem_ready beats", vec_beats[i], total_beats - beats_before);
    if (!is_fence && vec_beats[i] == 0) begin
      check_latency("fetch_ready latency", 1, latency);
    end
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %0d: %s %h ok, %0d cycles", i, vec_kind[i], vec_addr[i], latency);
    end else begin
      tests_failed++;
      $display("test %0d: %s %h FAILED", i, vec_kind[i], vec_addr[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr  = '0;
    void'($urandom(2186));
    read_vectors();
    if (vec_addr.size() == 0) begin
      $display("the vector file holds no vectors");
      error_count++;
    end
    cycle_limit = vec_addr.size() * 40;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i < vec_addr.size(); i++) begin
      run_vector(i);
    end
    $display("tests: %0d, ok: %0d, bad: %0d, errors: %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/itim_vectors.txt ====
# kind  address   expected fetch_rdata  expected memory beats
# fetch_rdata is ~(address+4) above ~address; a fence expects zero data, not compared
fence 00000000 0000000000000000 0
fetch 00001000 ffffeffbffffefff 2
fetch 00001000 ffffeffbffffefff 0
fetch 0000100c ffffefefffffeff3 2
fetch 0000100c ffffefefffffeff3 0
fetch 00001000 ffffeffbffffefff 0
# one word present and one empty, so the pair is filled again
fetch 00001010 ffffefebffffefef 2
fetch 00001010 ffffefebffffefef 0
fetch 0000100c ffffefefffffeff3 0
# outside the window
fetch 00003000 ffffcffbffffcfff 2
fetch 00003000 ffffcffbffffcfff 2
fetch 00003000 ffffcffbffffcfff 2
fetch 00001ffc ffffdfffffffe003 2
fetch 00001ffc ffffdfffffffe003 2
# same entries as 0x1000 with another tag
fetch 00001100 ffffeefbffffeeff 2
fetch 00001100 ffffeefbffffeeff 2
fetch 00001000 ffffeffbffffefff 0
fetch 00001018 ffffefe3ffffefe7 2
fetch 00001018 ffffefe3ffffefe7 0
fetch 00001020 ffffefdbffffefdf 2
fetch 00001020 ffffefdbffffefdf 0
# fence clears everything
fence 00000000 0000000000000000 0
fetch 00001000 ffffeffbffffefff 2
fetch 00001000 ffffeffbffffefff 0
fetch 0000100c ffffefefffffeff3 2
fetch 00001100 ffffeefbffffeeff 2
fetch 00001000 ffffeffbffffefff 0
